/* logic/decoder_pkg.sv */
package decoder_pkg;

    typedef logic [15:0] word_t;

    // instruction codes, low byte of the instruction word
    typedef enum logic [7:0] {
        NOP    = 8'h00,
        MOV_RR = 8'h01,
        LOAD   = 8'h02,
        ADD_RR = 8'h10,
        ADD_RI = 8'h11,
        SUB_RR = 8'h12,
        SUB_RI = 8'h13,
        AND_RR = 8'h14,
        AND_RI = 8'h15,
        OR_RR  = 8'h16,
        OR_RI  = 8'h17,
        XOR_RR = 8'h18,
        XOR_RI = 8'h19,
        INC    = 8'h20,
        DEC    = 8'h21,
        JMP    = 8'h30
    } opcode_t;

    // 1..6 select registers A..F
    typedef logic [3:0] reg_sel_t;

    localparam reg_sel_t REG_NULL = 4'h0;
    localparam reg_sel_t IMM_SEL  = 4'h8;

    typedef struct packed {
        logic [11:0] unused;
        reg_sel_t    sel;
    } reg_arg_t;

    // an argument is either a register selector or an immediate/address
    typedef union packed {
        word_t    raw;
        reg_arg_t regsel;
    } arg_word_u;

    typedef struct packed {
        opcode_t   opcode;
        arg_word_u arga;
        arg_word_u argb;
    } inst_bundle_t;

    typedef struct packed {
        logic set;
        logic out;
        logic lock;
    } pc_code_t;

    typedef enum logic [2:0] {
        MODE_RR   = 3'b000,
        MODE_IMM  = 3'b010,
        MODE_LOAD = 3'b100
    } alu_mode_t;

    typedef struct packed {
        logic [7:0] op;
        reg_sel_t   sel_b;
        reg_sel_t   sel_a;
        alu_mode_t  mode;
    } alu_code_t;

    typedef struct packed {
        pc_code_t  pc;
        logic      addr_en;
        alu_code_t alu;
        word_t     addr;
        word_t     data;
    } control_word_t;

    // number of argument words following the instruction word
    function automatic logic [1:0] arg_count(opcode_t op);
        case (op)
            INC, DEC, JMP: return 2'd1;
            MOV_RR, LOAD,
            ADD_RR, ADD_RI, SUB_RR, SUB_RI, AND_RR, AND_RI,
            OR_RR, OR_RI, XOR_RR, XOR_RI: return 2'd2;
            default: return 2'd0;
        endcase
    endfunction

endpackage

/* logic/word_collector.sv */
`timescale 1ns/1ps

module word_collector (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic                        i_word_req,
    input  decoder_pkg::word_t          i_word,
    output logic                        o_word_ack,
    output decoder_pkg::inst_bundle_t   o_bundle,
    output logic                        o_bundle_valid,
    input  logic                        i_enc_ready
);
    import decoder_pkg::*;

    typedef enum logic {
        W_IDLE,
        W_ACK
    } wstate_t;

    wstate_t    state;
    logic [1:0] cnt;
    opcode_t    op_in;
    logic [1:0] need;
    logic       last;
    logic       keep;
    logic       capture;

    // upper byte of the instruction word is ignored
    assign op_in = opcode_t'(i_word[7:0]);

    // argument count of the instruction being assembled
    assign need = (cnt == 2'd0) ? arg_count(op_in) : arg_count(o_bundle.opcode);
    assign last = (cnt == need);
    // zero-argument opcodes are NOP or unknown and get dropped
    assign keep = (need != 2'd0);

    // a finished bundle that is not taken blocks the next word
    assign capture = i_word_req && !o_word_ack && (!o_bundle_valid || i_enc_ready);

    assign o_word_ack = (state == W_ACK);

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state <= W_IDLE;
        end else begin
            case (state)
                W_IDLE: if (capture) state <= W_ACK;
                W_ACK:  if (!i_word_req) state <= W_IDLE;
                default: state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            cnt            <= 2'd0;
            o_bundle_valid <= 1'b0;
        end else begin
            if (o_bundle_valid && i_enc_ready) begin
                o_bundle_valid <= 1'b0;
            end
            if (capture) begin
                if (last) begin
                    cnt <= 2'd0;
                    if (keep) begin
                        o_bundle_valid <= 1'b1;
                    end
                end else begin
                    cnt <= cnt + 2'd1;
                end
            end
        end
    end

    // word slot chosen by the counter
    always_ff @(posedge clk) begin
        if (capture) begin
            case (cnt)
                2'd0:    o_bundle.opcode   <= op_in;
                2'd1:    o_bundle.arga.raw <= i_word;
                default: o_bundle.argb.raw <= i_word;
            endcase
        end
    end

endmodule

/* logic/control_encoder.sv */
`timescale 1ns/1ps

module control_encoder (
    input  logic                        clk,
    input  logic                        n_rst,
    input  decoder_pkg::inst_bundle_t   i_bundle,
    input  logic                        i_bundle_valid,
    output logic                        o_enc_ready,
    output decoder_pkg::control_word_t  o_ctrl,
    output logic                        o_ctrl_valid,
    input  logic                        i_issue_ready
);
    import decoder_pkg::*;

    control_word_t enc;
    logic          accept;

    // one output slot, free when empty or being drained
    assign o_enc_ready = !o_ctrl_valid || i_issue_ready;
    assign accept      = i_bundle_valid && o_enc_ready;

    always_comb begin
        enc        = '0;
        enc.alu.op = i_bundle.opcode;
        enc.pc.out = 1'b1;
        case (i_bundle.opcode)
            MOV_RR, ADD_RR, SUB_RR, AND_RR, OR_RR, XOR_RR: begin
                enc.alu.sel_a = i_bundle.arga.regsel.sel;
                enc.alu.sel_b = i_bundle.argb.regsel.sel;
                enc.alu.mode  = MODE_RR;
            end
            ADD_RI, SUB_RI, AND_RI, OR_RI, XOR_RI: begin
                enc.alu.sel_a = i_bundle.arga.regsel.sel;
                enc.alu.sel_b = IMM_SEL;
                enc.alu.mode  = MODE_IMM;
                enc.data      = i_bundle.argb.raw;
            end
            LOAD: begin
                // destination register comes first, value second
                enc.alu.sel_a = REG_NULL;
                enc.alu.sel_b = i_bundle.arga.regsel.sel;
                enc.alu.mode  = MODE_LOAD;
                enc.data      = i_bundle.argb.raw;
            end
            INC, DEC: begin
                enc.alu.sel_a = i_bundle.arga.regsel.sel;
                enc.alu.sel_b = REG_NULL;
                enc.alu.mode  = MODE_RR;
            end
            JMP: begin
                enc.alu     = '0;
                enc.pc.set  = 1'b1;
                enc.pc.out  = 1'b1;
                enc.addr_en = 1'b1;
                enc.addr    = i_bundle.arga.raw;
            end
            default: begin
                enc = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            o_ctrl_valid <= 1'b0;
        end else if (accept) begin
            o_ctrl_valid <= 1'b1;
        end else if (i_issue_ready) begin
            o_ctrl_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_ctrl <= enc;
        end
    end

endmodule

/* logic/control_issue.sv */
`timescale 1ns/1ps

module control_issue #(
    parameter int ISSUE_DEPTH = 2
) (
    input  logic                        clk,
    input  logic                        n_rst,
    input  decoder_pkg::control_word_t  i_ctrl,
    input  logic                        i_ctrl_valid,
    output logic                        o_issue_ready,
    output logic                        o_ctrl_req,
    output decoder_pkg::control_word_t  o_ctrl,
    input  logic                        i_ctrl_ack
);
    import decoder_pkg::*;

    localparam int PTR_W = (ISSUE_DEPTH > 1) ? $clog2(ISSUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(ISSUE_DEPTH + 1);

    typedef enum logic [1:0] {
        I_IDLE,
        I_REQ,
        I_WAIT
    } istate_t;

    control_word_t    mem [ISSUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    istate_t          state;
    logic             push;
    logic             pop;
    logic             start;

    assign o_issue_ready = (count != CNT_W'(ISSUE_DEPTH));
    assign push          = i_ctrl_valid && o_issue_ready;
    // the head leaves on the rising ack
    assign pop           = (state == I_REQ) && i_ctrl_ack;
    // a new request only once the previous ack is low again
    assign start = (count != '0) &&
                   ((state == I_IDLE) || ((state == I_WAIT) && !i_ctrl_ack));

    assign o_ctrl_req = (state == I_REQ);

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state <= I_IDLE;
        end else begin
            case (state)
                I_IDLE: if (start) state <= I_REQ;
                I_REQ:  if (i_ctrl_ack) state <= I_WAIT;
                I_WAIT: begin
                    if (!i_ctrl_ack) begin
                        state <= start ? I_REQ : I_IDLE;
                    end
                end
                default: state <= I_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(ISSUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(ISSUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_ctrl;
        end
    end

    // output copy keeps o_ctrl steady after the head is popped
    always_ff @(posedge clk) begin
        if (start) begin
            o_ctrl <= mem[rd_ptr];
        end
    end

endmodule

/* logic/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder #(
    parameter int ISSUE_DEPTH = 2
) (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic                        i_word_req,
    input  decoder_pkg::word_t          i_word,
    output logic                        o_word_ack,
    output logic                        o_ctrl_req,
    output decoder_pkg::control_word_t  o_ctrl,
    input  logic                        i_ctrl_ack
);
    import decoder_pkg::*;

    inst_bundle_t  bundle;
    logic          bundle_valid;
    logic          enc_ready;
    control_word_t ctrl;
    logic          ctrl_valid;
    logic          issue_ready;

    word_collector word_collector_inst (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_word_req     (i_word_req),
        .i_word         (i_word),
        .o_word_ack     (o_word_ack),
        .o_bundle       (bundle),
        .o_bundle_valid (bundle_valid),
        .i_enc_ready    (enc_ready)
    );

    control_encoder control_encoder_inst (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_bundle       (bundle),
        .i_bundle_valid (bundle_valid),
        .o_enc_ready    (enc_ready),
        .o_ctrl         (ctrl),
        .o_ctrl_valid   (ctrl_valid),
        .i_issue_ready  (issue_ready)
    );

    control_issue #(
        .ISSUE_DEPTH (ISSUE_DEPTH)
    ) control_issue_inst (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_ctrl        (ctrl),
        .i_ctrl_valid  (ctrl_valid),
        .o_issue_ready (issue_ready),
        .o_ctrl_req    (o_ctrl_req),
        .o_ctrl        (o_ctrl),
        .i_ctrl_ack    (i_ctrl_ack)
    );

endmodule

/* verification/decoder_chk.sv */
`timescale 1ns/1ps

module decoder_chk (
    input logic                        clk,
    input logic                        n_rst,
    input logic                        i_word_req,
    input decoder_pkg::word_t          i_word,
    input logic                        o_word_ack,
    input logic                        o_ctrl_req,
    input decoder_pkg::control_word_t  o_ctrl,
    input logic                        i_ctrl_ack
);

    int error_count;

    initial error_count = 0;

    // a request is held until it is acknowledged
    word_req_held: assert property (@(posedge clk) disable iff (!n_rst)
        i_word_req && !o_word_ack |=> i_word_req || o_word_ack)
        else begin
            $error("memory word request dropped before ack");
            error_count++;
        end

    ctrl_req_held: assert property (@(posedge clk) disable iff (!n_rst)
        o_ctrl_req && !i_ctrl_ack |=> o_ctrl_req)
        else begin
            $error("control request dropped before ack");
            error_count++;
        end

    // payloads do not move under a raised request
    word_stable: assert property (@(posedge clk) disable iff (!n_rst)
        i_word_req && $past(i_word_req) |-> $stable(i_word))
        else begin
            $error("memory word changed while requested");
            error_count++;
        end

    ctrl_stable: assert property (@(posedge clk) disable iff (!n_rst)
        o_ctrl_req && $past(o_ctrl_req) |-> $stable(o_ctrl))
        else begin
            $error("control word changed while requested");
            error_count++;
        end

    // the collector answers a request that was high when it captured
    word_ack_needs_req: assert property (@(posedge clk) disable iff (!n_rst)
        $rose(o_word_ack) |-> $past(i_word_req))
        else begin
            $error("memory ack raised without a request");
            error_count++;
        end

    ctrl_ack_needs_req: assert property (@(posedge clk) disable iff (!n_rst)
        $rose(i_ctrl_ack) |-> o_ctrl_req)
        else begin
            $error("control ack raised without a request");
            error_count++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        !n_rst |-> !o_word_ack && !o_ctrl_req && !i_ctrl_ack)
        else begin
            $error("handshake active during reset");
            error_count++;
        end

endmodule

bind inst_decoder decoder_chk decoder_chk_inst (.*);

/* verification/tb_inst_decoder.sv */
`timescale 1ns/1ps

module tb_inst_decoder;
    import decoder_pkg::*;

    localparam int ISSUE_DEPTH = 2;
    localparam int BURST_LEN   = ISSUE_DEPTH + 4;
    // words sent by rr, ri, one-arg, skip and burst tests
    localparam int TOTAL_WORDS = 18 + 18 + 6 + 13 + 3 * BURST_LEN;

    logic          clk;
    logic          n_rst;
    logic          i_word_req;
    word_t         i_word;
    logic          o_word_ack;
    logic          o_ctrl_req;
    control_word_t o_ctrl;
    logic          i_ctrl_ack;
    logic [31:0]   lfsr_state;

    inst_decoder #(
        .ISSUE_DEPTH (ISSUE_DEPTH)
    ) inst_decoder_inst (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_word_req (i_word_req),
        .i_word     (i_word),
        .o_word_ack (o_word_ack),
        .o_ctrl_req (o_ctrl_req),
        .o_ctrl     (o_ctrl),
        .i_ctrl_ack (i_ctrl_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    initial begin
        repeat (200 * TOTAL_WORDS + 100) @(posedge clk);
        stop_on_error("timeout: the decoder stopped moving words before the tests finished");
    end

    initial begin
        wait (inst_decoder_inst.decoder_chk_inst.error_count != 0);
        stop_on_error("a handshake assertion in the bound checker failed");
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // registers A..F
    function automatic reg_sel_t pick_reg();
        return reg_sel_t'(rand_bits(3) % 6 + 1);
    endfunction

    function automatic int args_of(input logic [7:0] code);
        if (code == INC || code == DEC || code == JMP) return 1;
        if (code == MOV_RR || code == LOAD || (code[7:4] == 4'h1 && code[3:0] <= 4'h9)) return 2;
        return 0;
    endfunction

    // LOAD and the odd codes of the 0x1x row take an immediate
    function automatic bit is_imm_form(input logic [7:0] code);
        return code == LOAD || (code[7:4] == 4'h1 && code[0]);
    endfunction

    function automatic inst_bundle_t make_inst(input opcode_t op);
        inst_bundle_t b;
        b = '0;
        b.opcode = op;
        if (op == JMP) b.arga.raw = rand_bits(16);
        else b.arga.raw = {12'h000, pick_reg()};
        if (args_of(op) == 2) begin
            if (is_imm_form(op)) b.argb.raw = rand_bits(16);
            else b.argb.raw = {12'h000, pick_reg()};
        end
        return b;
    endfunction

    function automatic control_word_t expected_ctrl(input inst_bundle_t b);
        control_word_t c;
        logic [7:0]    code;
        c    = '0;
        code = b.opcode;
        if (code == JMP) begin
            c.pc.set  = 1'b1;
            c.pc.out  = 1'b1;
            c.addr_en = 1'b1;
            c.addr    = b.arga.raw;
            return c;
        end
        c.pc.out = 1'b1;
        c.alu.op = code;
        if (code == LOAD) begin
            c.alu.sel_b = b.arga.regsel.sel;
            c.alu.mode  = MODE_LOAD;
            c.data      = b.argb.raw;
        end else if (code == INC || code == DEC) begin
            c.alu.sel_a = b.arga.regsel.sel;
        end else if (is_imm_form(code)) begin
            c.alu.sel_a = b.arga.regsel.sel;
            c.alu.sel_b = IMM_SEL;
            c.alu.mode  = MODE_IMM;
            c.data      = b.argb.raw;
        end else begin
            c.alu.sel_a = b.arga.regsel.sel;
            c.alu.sel_b = b.argb.regsel.sel;
        end
        return c;
    endfunction

    task automatic check_ctrl(input string name, input control_word_t exp, input control_word_t got);
        if (got !== exp) stop_on_error($sformatf("FAIL %s expected %h actual %h", name, exp, got));
    endtask

    task automatic check_alu(input string name, input alu_code_t exp, input alu_code_t got);
        if (got !== exp) stop_on_error($sformatf("FAIL %s expected %h actual %h", name, exp, got));
    endtask

    // one clock, ending at the drive point 2 ns after the edge
    task automatic wait_cycle();
        @(posedge clk);
        #2;
    endtask

    // drives one memory word through all four phases
    task automatic send_word(input word_t w);
        i_word     = w;
        i_word_req = 1'b1;
        do wait_cycle(); while (!o_word_ack);
        i_word_req = 1'b0;
        do wait_cycle(); while (o_word_ack);
    endtask

    task automatic feed_inst(input inst_bundle_t b);
        int         n;
        logic [7:0] upper;
        n     = args_of(b.opcode);
        // upper byte of the instruction word is don't care
        upper = 8'(rand_bits(8));
        send_word({upper, b.opcode});
        if (n >= 1) send_word(b.arga.raw);
        if (n == 2) send_word(b.argb.raw);
    endtask

    // answers one control request after extra cycles of delay
    task automatic take_ctrl(output control_word_t got, input int extra);
        do wait_cycle(); while (!o_ctrl_req);
        got = o_ctrl;
        repeat (extra) wait_cycle();
        i_ctrl_ack = 1'b1;
        do wait_cycle(); while (o_ctrl_req);
        i_ctrl_ack = 1'b0;
    endtask

    task automatic run_program(input string name, input inst_bundle_t prog[$], input int delay,
                               input bit per_op);
        control_word_t exp_q[$];
        control_word_t got;
        control_word_t exp;
        int            n_real;
        n_real = 0;
        foreach (prog[i]) begin
            if (args_of(prog[i].opcode) != 0) n_real++;
        end
        fork
            begin
                foreach (prog[i]) begin
                    if (args_of(prog[i].opcode) != 0) exp_q.push_back(expected_ctrl(prog[i]));
                    feed_inst(prog[i]);
                end
            end
            begin
                repeat (n_real) begin
                    take_ctrl(got, delay);
                    exp = exp_q.pop_front();
                    if (per_op) check_alu(name, exp.alu, got.alu);
                    check_ctrl(name, exp, got);
                end
            end
        join
    endtask

    task automatic rr_ops_test();
        opcode_t      ops[6];
        inst_bundle_t prog[$];
        ops = '{ADD_RR, SUB_RR, AND_RR, OR_RR, XOR_RR, MOV_RR};
        foreach (ops[i]) begin
            prog = {make_inst(ops[i])};
            run_program($sformatf("rr_ops %s", ops[i].name()), prog, 0, 1'b1);
        end
    endtask

    task automatic ri_ops_test();
        opcode_t      ops[6];
        inst_bundle_t prog[$];
        ops = '{ADD_RI, SUB_RI, AND_RI, OR_RI, XOR_RI, LOAD};
        foreach (ops[i]) begin
            prog = {make_inst(ops[i])};
            run_program($sformatf("ri_ops %s", ops[i].name()), prog, 1, 1'b1);
        end
    endtask

    task automatic one_arg_test();
        opcode_t      ops[3];
        inst_bundle_t prog[$];
        ops = '{INC, DEC, JMP};
        foreach (ops[i]) begin
            prog = {make_inst(ops[i])};
            run_program($sformatf("one_arg %s", ops[i].name()), prog, 2, 1'b1);
        end
    endtask

    task automatic skip_codes_test();
        inst_bundle_t prog[$];
        prog.push_back(make_inst(ADD_RI));
        prog.push_back(make_inst(NOP));
        prog.push_back(make_inst(opcode_t'(8'h45)));
        prog.push_back(make_inst(LOAD));
        prog.push_back(make_inst(opcode_t'(8'hff)));
        prog.push_back(make_inst(INC));
        prog.push_back(make_inst(NOP));
        prog.push_back(make_inst(opcode_t'(8'h22)));
        run_program("skip_codes", prog, 0, 1'b0);
        // trailing NOP and unknown codes must stay silent
        repeat (10) begin
            wait_cycle();
            if (o_ctrl_req) stop_on_error("a control word was issued for a NOP or unknown opcode");
        end
    endtask

    // the slow executor fills the queue, the encoder and the held bundle
    task automatic back_pressure_test();
        opcode_t      ops[4];
        inst_bundle_t prog[$];
        ops = '{SUB_RI, XOR_RR, LOAD, OR_RI};
        for (int i = 0; i < BURST_LEN; i++) prog.push_back(make_inst(ops[i % 4]));
        run_program("back_pressure", prog, 12, 1'b0);
    endtask

    initial begin
        lfsr_state = 32'h09a50d28;
        n_rst      = 1'b0;
        i_word_req = 1'b0;
        i_word     = '0;
        i_ctrl_ack = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        n_rst = 1'b1;
        @(posedge clk);
        #2;
        rr_ops_test();
        ri_ops_test();
        one_arg_test();
        skip_codes_test();
        back_pressure_test();
        $display("TEST PASS");
        $finish;
    end

endmodule

/* tb.f */
logic/decoder_pkg.sv
logic/word_collector.sv
logic/control_encoder.sv
logic/control_issue.sv
logic/inst_decoder.sv
verification/decoder_chk.sv
verification/tb_inst_decoder.sv
